// ==== branchUnit.f ====
design/bpuTypesPkg.sv
design/bpuConfigPkg.sv
design/bpuUpdateIf.sv
design/returnStack.sv
design/branchPredictor.sv
design/branchSolve.sv
design/branchUnit.sv
bench/branchUnit_assert.sv
bench/branchUnitTb.sv

// ==== Bender.yml ====
package:
  name: branchUnit

sources:
  - files:
      - design/bpuTypesPkg.sv
      - design/bpuConfigPkg.sv
      - design/bpuUpdateIf.sv
      - design/returnStack.sv
      - design/branchPredictor.sv
      - design/branchSolve.sv
      - design/branchUnit.sv
  - target: test
    files:
      - bench/branchUnit_assert.sv
      - bench/branchUnitTb.sv

// ==== bench/branchUnitTb.sv ====
// branch unit testbench that drives fetch and execute, models the predictor and checks the outputs
`timescale 1ns/1ns

module branchUnitTb;
    import bpuTypesPkg::*;

    localparam int resetCycles = 8;
    // reset and miss, conditional, jumps, gating, counter, stack, with one idle cycle each
    localparam int testCycles  = 7 + 49 + 9 + 9 + 10 + 11;
    localparam int timeoutNs   = (resetCycles + testCycles) * 10 + 500;

    logic        clk;
    logic        arstN;
    logic        fetchValid;
    logic [31:0] fetchPc;
    logic        predValid;
    logic        predHit;
    branchKindT  predKind;
    logic        predTaken;
    logic [31:0] predTarget;
    logic [1:0]  predCount;
    branchTypeT  exeBranchType;
    logic        exeIsCall;
    logic [31:0] exeOutA;
    logic [31:0] exeOutB;
    logic [31:0] exePc;
    logic [31:0] exeInstr;
    logic [31:0] exeImm32;
    logic        exeWr;
    logic        exePredValid;
    logic        exePredHit;
    branchKindT  exePredKind;
    logic        exePredTaken;
    logic [31:0] exePredTarget;
    logic [1:0]  exePredCount;
    logic        predictionFailed;
    logic [31:0] correctionVector;

    // target buffer and return stack model
    logic [23:0] mTag    [64];
    logic [31:0] mTarget [64];
    branchKindT  mKind   [64];
    logic [1:0]  mCount  [64];
    logic [63:0] mValid;
    logic [31:0] mRas    [8];
    logic [2:0]  mPtr;

    predResultT  expPred;
    logic        expFail;
    logic [31:0] expVec;
    logic        combArmed;
    logic        fetchArmed;

    logic [31:0] lcgState;
    string       curTest;
    int          testErrs;
    int          totalErrs;
    int          testsRun;
    int          testsBad;

    branchUnit dut0 (.*);

    bind branchUnit branchUnitAssert assert0 (
        .clk              (clk),
        .arstN            (arstN),
        .fetchValid       (fetchValid),
        .predValid        (predValid),
        .exeWr            (exeWr),
        .predictionFailed (predictionFailed)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic logic [1:0] satStep(input logic [1:0] cnt, input logic up);
        if (up) begin
            return (cnt == 2'd3) ? cnt : cnt + 2'd1;
        end else begin
            return (cnt == 2'd0) ? cnt : cnt - 2'd1;
        end
    endfunction

    // kind, direction and target of the instruction in execute
    function automatic predResultT refResolve(input branchTypeT bt, input logic isCall,
            input logic [31:0] a, input logic [31:0] b, input logic [31:0] pc,
            input logic [31:0] instr, input logic [31:0] imm);
        predResultT  r;
        logic [31:0] pc4;
        pc4      = pc + 32'd4;
        r        = '0;
        r.valid  = 1'b1;
        r.kind   = kindNone;
        r.target = pc + 32'd8; // fall through past the delay slot
        if (bt.isBranch) begin
            case (bt.branchCode)
                J: begin
                    r.kind    = isCall ? kindCall : kindImme;
                    r.isTaken = 1'b1;
                    r.target  = {pc4[31:28], instr[25:0], 2'b00};
                end
                JR: begin
                    r.kind    = isCall ? kindCall : kindRetn;
                    r.isTaken = 1'b1;
                    r.target  = a;
                end
                default: begin
                    r.kind = kindImme;
                    case (bt.branchCode)
                        BEQ:     r.isTaken = (a == b);
                        BNE:     r.isTaken = (a != b);
                        BGE:     r.isTaken = ($signed(a) >= 0);
                        BGT:     r.isTaken = ($signed(a) > 0);
                        BLE:     r.isTaken = ($signed(a) <= 0);
                        BLT:     r.isTaken = ($signed(a) < 0);
                        default: r.isTaken = 1'b0;
                    endcase
                    if (r.isTaken) begin
                        r.target = pc4 + (imm << 2);
                    end
                end
            endcase
        end
        return r;
    endfunction

    function automatic predResultT modelLookup(input logic [31:0] pc);
        predResultT p;
        int         idx;
        idx      = pc[7:2];
        p        = '0;
        p.valid  = 1'b1;
        p.kind   = kindNone;
        p.target = pc + 32'd8;
        if (mValid[idx] && mTag[idx] == pc[31:8]) begin
            p.hit     = 1'b1;
            p.kind    = mKind[idx];
            p.count   = mCount[idx];
            p.isTaken = (mKind[idx] == kindImme) ? mCount[idx][1] : 1'b1;
            p.target  = (mKind[idx] == kindRetn) ? mRas[mPtr] : mTarget[idx];
        end
        return p;
    endfunction

    task automatic modelUpdate(input updateRecT rec);
        int idx;
        idx = rec.pc[7:2];
        if (rec.valid) begin
            if (rec.hit) begin
                mCount[idx]  = satStep(rec.count, rec.isTaken);
                mKind[idx]   = rec.kind;
                mTarget[idx] = rec.target;
            end else if (rec.kind != kindNone) begin
                mValid[idx]  = 1'b1;
                mTag[idx]    = rec.pc[31:8];
                mKind[idx]   = rec.kind;
                mTarget[idx] = rec.target;
                mCount[idx]  = 2'd2; // weakly taken
            end
            if (rec.kind == kindCall) begin
                mPtr       = mPtr + 3'd1;
                mRas[mPtr] = rec.pc + 32'd8;
            end else if (rec.kind == kindRetn) begin
                mPtr = mPtr - 3'd1;
            end
        end
    endtask

    task automatic checkEq(input string name, input logic [31:0] expected,
            input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
            testErrs++;
            totalErrs++;
        end
    endtask

    task automatic setPred(input predResultT p);
        exePredValid  = p.valid;
        exePredHit    = p.hit;
        exePredKind   = p.kind;
        exePredTaken  = p.isTaken;
        exePredTarget = p.target;
        exePredCount  = p.count;
    endtask

    task automatic idleInputs();
        fetchValid    = 1'b0;
        fetchPc       = 32'h0;
        exeBranchType = '0;
        exeIsCall     = 1'b0;
        exeOutA       = 32'h0;
        exeOutB       = 32'h0;
        exePc         = 32'h0;
        exeInstr      = 32'h0;
        exeImm32      = 32'h0;
        exeWr         = 1'b0;
        setPred('0);
    endtask

    task automatic driveExe(input branchCodeT code, input logic isCall, input logic [31:0] a,
            input logic [31:0] b, input logic [31:0] pc, input logic [31:0] instr,
            input logic [31:0] imm);
        exeBranchType.isBranch   = 1'b1;
        exeBranchType.branchCode = code;
        exeIsCall = isCall;
        exeOutA   = a;
        exeOutB   = b;
        exePc     = pc;
        exeInstr  = instr;
        exeImm32  = imm;
        exeWr     = 1'b1;
    endtask

    // one cycle with expectations from the current inputs, then the edge and the model update
    task automatic tick();
        predResultT look;
        predResultT res;
        updateRecT  rec;
        logic       fv;
        look    = modelLookup(fetchPc); // lookup sees the table before this edge
        fv      = fetchValid;
        res     = refResolve(exeBranchType, exeIsCall, exeOutA, exeOutB, exePc, exeInstr,
                             exeImm32);
        expVec  = res.target;
        expFail = exePredValid && exeWr && (res.kind != exePredKind ||
                  res.isTaken != exePredTaken || res.target != exePredTarget);
        rec.valid   = exePredValid && exeWr;
        rec.pc      = exePc;
        rec.kind    = res.kind;
        rec.isTaken = res.isTaken;
        rec.target  = res.target;
        rec.count   = exePredCount;
        rec.hit     = exePredHit;
        combArmed   = 1'b1;
        @(posedge clk);
        #1;
        modelUpdate(rec);
        expPred       = look;
        expPred.valid = fv;
        fetchArmed    = 1'b1;
    endtask

    task automatic resolveAt(input branchCodeT code, input logic isCall, input logic [31:0] a,
            input logic [31:0] pc);
        idleInputs();
        driveExe(code, isCall, a, 32'h0, pc, nextRand(), 32'h0);
        setPred(modelLookup(pc)); // what the pipeline would have carried
        tick();
    endtask

    task automatic lookupAt(input logic [31:0] pc);
        idleInputs();
        fetchValid = 1'b1;
        fetchPc    = pc;
        tick();
    endtask

    task automatic endTest();
        idleInputs();
        tick(); // drains the last prediction into the compare
        testsRun++;
        if (testErrs != 0) begin
            testsBad++;
        end
        $display("%s: %s, %0d mismatches", curTest, (testErrs == 0) ? "ok" : "FAIL", testErrs);
        testErrs = 0;
    endtask

    always @(negedge clk) begin
        if (combArmed) begin
            checkEq({curTest, " predictionFailed"}, expFail, predictionFailed);
            checkEq({curTest, " correctionVector"}, expVec, correctionVector);
        end
        if (fetchArmed) begin
            checkEq({curTest, " predValid"}, expPred.valid, predValid);
            if (expPred.valid) begin
                checkEq({curTest, " predHit"}, expPred.hit, predHit);
                checkEq({curTest, " predKind"}, expPred.kind, predKind);
                checkEq({curTest, " predTaken"}, expPred.isTaken, predTaken);
                checkEq({curTest, " predTarget"}, expPred.target, predTarget);
                checkEq({curTest, " predCount"}, expPred.count, predCount);
            end
        end
    end

    task automatic testResetMiss();
        int i;
        curTest = "resetMiss";
        tick();
        tick(); // no fetch yet, predValid stays low
        for (i = 0; i < 4; i++) begin
            lookupAt(nextRand() & 32'hffff_fffc);
            checkEq({curTest, " miss hit"}, 32'd0, predHit);
            checkEq({curTest, " miss kind"}, kindNone, predKind);
            checkEq({curTest, " miss target"}, fetchPc + 32'd8, predTarget);
        end
        endTest();
    endtask

    task automatic testCondBranch();
        logic [31:0] edges [4];
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [31:0] pc;
        predResultT  p;
        int          c;
        int          k;
        curTest = "condBranch";
        edges = '{32'h0, 32'h8000_0000, 32'h7fff_ffff, 32'hffff_ffff};
        for (c = 0; c < 6; c++) begin
            for (k = 0; k < 8; k++) begin
                a  = (k < 4) ? edges[k] : nextRand();
                b  = k[0] ? nextRand() : a;
                pc = nextRand() & 32'hffff_fffc;
                r  = nextRand();
                idleInputs();
                driveExe(branchCodeT'(c), 1'b0, a, b, pc, 32'h0, {{16{r[15]}}, r[15:0]});
                p        = '0;
                p.valid  = 1'b1;
                p.kind   = kindImme;
                p.target = pc + 32'd8; // predicted not taken so the flag shows the direction
                setPred(p);
                tick();
            end
        end
        endTest();
    endtask

    task automatic testJumps();
        logic [31:0] a;
        logic [31:0] pc;
        logic [31:0] instr;
        predResultT  p;
        int          j;
        int          w;
        curTest = "jumps";
        for (j = 0; j < 4; j++) begin
            for (w = 0; w < 2; w++) begin
                a     = nextRand() & 32'hffff_fffc;
                pc    = nextRand() & 32'hffff_fffc;
                instr = nextRand();
                idleInputs();
                driveExe((j < 2) ? J : JR, j[0], a, 32'h0, pc, instr, 32'h0);
                p = refResolve(exeBranchType, j[0], a, 32'h0, pc, instr, 32'h0);
                if (w == 1) begin
                    p.kind = branchKindT'(p.kind ^ 2'b01); // wrong kind, right target
                end
                setPred(p);
                tick();
            end
        end
        endTest();
    endtask

    task automatic testGating();
        predResultT  good;
        predResultT  p;
        logic [31:0] gatedPc;
        int          i;
        curTest = "mispredictGating";
        idleInputs();
        driveExe(BEQ, 1'b0, 32'h55, 32'h55, 32'h0000_1a20, 32'h0, 32'h10);
        good = refResolve(exeBranchType, 1'b0, 32'h55, 32'h55, 32'h0000_1a20, 32'h0, 32'h10);
        for (i = 0; i < 4; i++) begin
            p = good;
            if (i == 1) p.kind = kindCall;
            if (i == 2) p.isTaken = 1'b0;
            if (i == 3) p.target = good.target + 32'd4;
            setPred(p);
            tick();
        end
        // stalled execute, then a dead prediction
        for (i = 0; i < 2; i++) begin
            gatedPc = 32'h00ab_cd40 + i * 32'h100;
            idleInputs();
            driveExe(BEQ, 1'b0, 32'h55, 32'h55, gatedPc, 32'h0, 32'h10);
            p       = good;
            p.kind  = kindCall;
            p.valid = (i == 0);
            exeWr   = (i == 1);
            setPred(p);
            tick();
            lookupAt(gatedPc);
            checkEq({curTest, " no update"}, 32'd0, predHit);
        end
        endTest();
    endtask

    task automatic testCounter();
        logic [31:0] q;
        int          i;
        curTest = "counterTraining";
        q = 32'h0000_2010;
        for (i = 0; i < 8; i++) begin
            idleInputs();
            fetchValid = 1'b1;
            fetchPc    = q;
            driveExe(BNE, 1'b0, 32'h1, (i < 4) ? 32'h2 : 32'h1, q, 32'h0, 32'h20);
            setPred(modelLookup(q));
            tick();
            if (i == 1) begin
                checkEq({curTest, " alloc count"}, 32'd2, predCount);
                checkEq({curTest, " alloc taken"}, 32'd1, predTaken);
            end
            if (i == 3) begin
                checkEq({curTest, " high saturate"}, 32'd3, predCount);
            end
        end
        lookupAt(q);
        checkEq({curTest, " low saturate"}, 32'd0, predCount);
        checkEq({curTest, " not taken"}, 32'd0, predTaken);
        endTest();
    endtask

    task automatic testReturnStack();
        logic [31:0] retPc;
        logic [31:0] callPc [3];
        int          i;
        curTest = "returnStack";
        retPc  = 32'h0000_3184;
        callPc = '{32'h0000_4010, 32'h0000_4024, 32'h0000_4038};
        resolveAt(JR, 1'b0, 32'h0, retPc); // trains the return pc, pops once
        resolveAt(J, 1'b1, 32'h0, callPc[0]);
        lookupAt(retPc);
        checkEq({curTest, " single call"}, callPc[0] + 32'd8, predTarget);
        resolveAt(J, 1'b1, 32'h0, callPc[1]);
        resolveAt(J, 1'b1, 32'h0, callPc[2]);
        for (i = 2; i > 0; i--) begin
            lookupAt(retPc);
            checkEq({curTest, " nested return"}, callPc[i] + 32'd8, predTarget);
            resolveAt(JR, 1'b0, callPc[i] + 32'd8, retPc);
        end
        lookupAt(retPc);
        checkEq({curTest, " outer return"}, callPc[0] + 32'd8, predTarget);
        endTest();
    endtask

    initial begin
        lcgState   = 32'd81;
        curTest    = "reset";
        testErrs   = 0;
        totalErrs  = 0;
        testsRun   = 0;
        testsBad   = 0;
        combArmed  = 1'b0;
        fetchArmed = 1'b0;
        expPred    = '0;
        expFail    = 1'b0;
        expVec     = 32'h0;
        mValid     = '0;
        mPtr       = '0;
        arstN      = 1'b0;
        idleInputs();
        repeat (resetCycles) @(posedge clk);
        #1;
        arstN = 1'b1;
        testResetMiss();
        testCondBranch();
        testJumps();
        testGating();
        testCounter();
        testReturnStack();
        @(negedge clk);
        #1;
        $display("summary: %0d tests, %0d with mismatches, %0d mismatches, %0d assertion errors",
                 testsRun, testsBad, totalErrs, dut0.assert0.assertFails);
        if (totalErrs == 0 && dut0.assert0.assertFails == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // watchdog sized from the test cycle counts
    initial begin
        #(timeoutNs);
        $display("timeout: run did not finish within %0d ns", timeoutNs);
        $display("tests failed");
        $finish;
    end

endmodule

// ==== bench/branchUnit_assert.sv ====
// branch unit assertions on the reset state, prediction valid timing and flag gating
`timescale 1ns/1ns

module branchUnitAssert (
    input logic clk,
    input logic arstN,
    input logic fetchValid,
    input logic predValid,
    input logic exeWr,
    input logic predictionFailed
);

    int assertFails = 0; // read by the testbench summary

    // async reset holds the registered valid low
    resetClearsValid: assert property (@(posedge clk) !arstN |-> !predValid)
        else begin
            assertFails++;
            $error("predValid high while reset is asserted");
        end

    validFollowsFetch: assert property (@(posedge clk) disable iff (!arstN)
            predValid == $past(fetchValid))
        else begin
            assertFails++;
            $error("predValid does not follow fetchValid by one cycle");
        end

    // a stalled execute stage never flags
    flagNeedsWrite: assert property (@(posedge clk) disable iff (!arstN)
            !exeWr |-> !predictionFailed)
        else begin
            assertFails++;
            $error("predictionFailed high while exeWr is low");
        end

endmodule

// ==== design/branchUnit.sv ====
// branch unit top joining the fetch predictor and the execute resolver by the update channel
`timescale 1ns/1ns

module branchUnit (
    input  logic                    clk,
    input  logic                    arstN,
    // fetch side
    input  logic                    fetchValid,
    input  logic [31:0]             fetchPc,
    output logic                    predValid,
    output logic                    predHit,
    output bpuTypesPkg::branchKindT predKind,
    output logic                    predTaken,
    output logic [31:0]             predTarget,
    output logic [1:0]              predCount,
    // execute side
    input  bpuTypesPkg::branchTypeT exeBranchType,
    input  logic                    exeIsCall,
    input  logic [31:0]             exeOutA,
    input  logic [31:0]             exeOutB,
    input  logic [31:0]             exePc,
    input  logic [31:0]             exeInstr,
    input  logic [31:0]             exeImm32,
    input  logic                    exeWr,
    input  logic                    exePredValid,
    input  logic                    exePredHit,
    input  bpuTypesPkg::branchKindT exePredKind,
    input  logic                    exePredTaken,
    input  logic [31:0]             exePredTarget,
    input  logic [1:0]              exePredCount,
    output logic                    predictionFailed,
    output logic [31:0]             correctionVector
);
    import bpuTypesPkg::*;

    predResultT fetchPred;
    predResultT exePred;

    bpuUpdateIf updIf0 ();

    // prediction fields carried down the pipeline
    assign exePred.valid   = exePredValid;
    assign exePred.hit     = exePredHit;
    assign exePred.kind    = exePredKind;
    assign exePred.isTaken = exePredTaken;
    assign exePred.target  = exePredTarget;
    assign exePred.count   = exePredCount;

    branchPredictor predictor0 (
        .clk        (clk),
        .arstN      (arstN),
        .fetchValid (fetchValid),
        .fetchPc    (fetchPc),
        .upd        (updIf0.pred),
        .pred       (fetchPred)
    );

    branchSolve solve0 (
        .exeBranchType    (exeBranchType),
        .exeIsCall        (exeIsCall),
        .exeOutA          (exeOutA),
        .exeOutB          (exeOutB),
        .exePc            (exePc),
        .exeInstr         (exeInstr),
        .exeImm32         (exeImm32),
        .exeWr            (exeWr),
        .exePred          (exePred),
        .predictionFailed (predictionFailed),
        .correctionVector (correctionVector),
        .upd              (updIf0.res)
    );

    assign predValid  = fetchPred.valid;
    assign predHit    = fetchPred.hit;
    assign predKind   = fetchPred.kind;
    assign predTaken  = fetchPred.isTaken;
    assign predTarget = fetchPred.target;
    assign predCount  = fetchPred.count;

endmodule

// ==== design/branchSolve.sv ====
// execute-side branch resolver for direction, target, kind and the misprediction check
`timescale 1ns/1ns

module branchSolve (
    input  bpuTypesPkg::branchTypeT exeBranchType,
    input  logic                    exeIsCall,
    input  logic [31:0]             exeOutA,
    input  logic [31:0]             exeOutB,
    input  logic [31:0]             exePc,
    input  logic [31:0]             exeInstr,
    input  logic [31:0]             exeImm32,
    input  logic                    exeWr,
    input  bpuTypesPkg::predResultT exePred,
    output logic                    predictionFailed,
    output logic [31:0]             correctionVector,
    bpuUpdateIf.res                 upd
);
    import bpuTypesPkg::*;

    logic        isTaken;
    logic [31:0] branchTarget;
    branchKindT  branchKind;
    logic        predMatch;

    logic [31:0] pcPlus4;
    logic [31:0] jumpAddr;
    logic [31:0] branchAddr;

    logic opEqual;
    logic opAZero;
    logic opANeg;

    assign opEqual = (exeOutA == exeOutB);
    assign opAZero = (exeOutA == 32'd0);
    assign opANeg  = exeOutA[31];

    assign pcPlus4    = exePc + 32'd4;
    assign jumpAddr   = {pcPlus4[31:28], exeInstr[25:0], 2'b00};
    assign branchAddr = pcPlus4 + {exeImm32[29:0], 2'b00};

    // direction
    always_comb begin
        isTaken = 1'b0;
        if (exeBranchType.isBranch) begin
            unique case (exeBranchType.branchCode)
                BEQ:     isTaken = opEqual;
                BNE:     isTaken = !opEqual;
                BGE:     isTaken = !opANeg;
                BGT:     isTaken = !opANeg && !opAZero;
                BLE:     isTaken = opANeg || opAZero;
                BLT:     isTaken = opANeg;
                default: isTaken = 1'b1; // J and JR
            endcase
        end
    end

    // kind and target
    always_comb begin
        branchKind   = kindNone;
        branchTarget = exePc + 32'd8;
        if (exeBranchType.isBranch) begin
            unique case (exeBranchType.branchCode)
                J: begin
                    branchKind   = exeIsCall ? kindCall : kindImme;
                    branchTarget = jumpAddr;
                end
                JR: begin
                    branchKind   = exeIsCall ? kindCall : kindRetn; // jr treated as return
                    branchTarget = exeOutA;
                end
                default: begin
                    branchKind = kindImme;
                    if (isTaken) begin
                        branchTarget = branchAddr;
                    end
                end
            endcase
        end
    end

    assign predMatch = (exePred.kind == branchKind) &&
                       (exePred.isTaken == isTaken) &&
                       (exePred.target == branchTarget);

    // flag only for a live prediction in a writing stage
    assign predictionFailed = !predMatch && exePred.valid && exeWr;
    assign correctionVector = branchTarget;

    assign upd.rec.valid   = exePred.valid && exeWr;
    assign upd.rec.pc      = exePc;
    assign upd.rec.kind    = branchKind;
    assign upd.rec.isTaken = isTaken;
    assign upd.rec.target  = branchTarget;
    assign upd.rec.count   = exePred.count;
    assign upd.rec.hit     = exePred.hit;

endmodule

// ==== design/branchPredictor.sv ====
// fetch-side branch predictor with a direct-mapped target buffer, 2-bit counters and a return stack
`timescale 1ns/1ns

module branchPredictor (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic                    fetchValid,
    input  logic [31:0]             fetchPc,
    bpuUpdateIf.pred                upd,
    output bpuTypesPkg::predResultT pred
);
    import bpuTypesPkg::*;
    import bpuConfigPkg::*;

    // target buffer storage
    logic [btbTagW-1:0] tagMem    [btbEntries];
    logic [31:0]        targetMem [btbEntries];
    branchKindT         kindMem   [btbEntries];
    counterT            countMem  [btbEntries];
    logic [btbEntries-1:0] entryValid;

    logic [btbIndexW-1:0] fetchIdx;
    logic [btbTagW-1:0]   fetchTag;
    logic [btbIndexW-1:0] updIdx;
    logic [btbTagW-1:0]   updTag;
    logic                 lookupHit;
    predResultT           lookup;

    logic        rasPush;
    logic        rasPop;
    logic [31:0] rasTop;

    logic       predValidQ;
    predResultT predPayloadQ;

    function automatic counterT satCount(input counterT cnt, input logic taken);
        counterT res;
        res = cnt;
        if (taken && cnt != 2'd3) begin
            res = cnt + 2'd1;
        end else if (!taken && cnt != 2'd0) begin
            res = cnt - 2'd1;
        end
        return res;
    endfunction

    assign fetchIdx = fetchPc[btbIndexW+1:2];
    assign fetchTag = fetchPc[31:btbIndexW+2];
    assign updIdx   = upd.rec.pc[btbIndexW+1:2];
    assign updTag   = upd.rec.pc[31:btbIndexW+2];

    // lookup reads the arrays before this edge's update lands
    assign lookupHit = entryValid[fetchIdx] && (tagMem[fetchIdx] == fetchTag);

    always_comb begin
        lookup.valid = fetchValid;
        if (lookupHit) begin
            lookup.hit   = 1'b1;
            lookup.kind  = kindMem[fetchIdx];
            lookup.count = countMem[fetchIdx];
            // calls and returns are always taken
            if (kindMem[fetchIdx] == kindImme) begin
                lookup.isTaken = countMem[fetchIdx][1];
            end else begin
                lookup.isTaken = 1'b1;
            end
            if (kindMem[fetchIdx] == kindRetn) begin
                lookup.target = rasTop;
            end else begin
                lookup.target = targetMem[fetchIdx];
            end
        end else begin
            lookup.hit     = 1'b0;
            lookup.kind    = kindNone;
            lookup.count   = 2'd0;
            lookup.isTaken = 1'b0;
            lookup.target  = fetchPc + 32'd8; // past the delay slot
        end
    end

    // registered prediction, one cycle behind fetch
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            predValidQ <= 1'b0;
        end else begin
            predValidQ <= fetchValid;
        end
    end

    always_ff @(posedge clk) begin
        predPayloadQ <= lookup;
    end

    always_comb begin
        pred       = predPayloadQ;
        pred.valid = predValidQ;
    end

    // valid bits set on allocation only
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            entryValid <= '0;
        end else if (upd.rec.valid && !upd.rec.hit && upd.rec.kind != kindNone) begin
            entryValid[updIdx] <= 1'b1;
        end
    end

    // training on a hit, allocation on a miss
    always_ff @(posedge clk) begin
        if (upd.rec.valid) begin
            if (upd.rec.hit) begin
                countMem[updIdx]  <= satCount(upd.rec.count, upd.rec.isTaken);
                kindMem[updIdx]   <= upd.rec.kind;
                targetMem[updIdx] <= upd.rec.target;
            end else if (upd.rec.kind != kindNone) begin
                tagMem[updIdx]    <= updTag;
                kindMem[updIdx]   <= upd.rec.kind;
                targetMem[updIdx] <= upd.rec.target;
                countMem[updIdx]  <= counterInit;
            end
        end
    end

    // stack moves only on resolved calls and returns
    assign rasPush = upd.rec.valid && (upd.rec.kind == kindCall);
    assign rasPop  = upd.rec.valid && (upd.rec.kind == kindRetn);

    returnStack ras0 (
        .clk      (clk),
        .arstN    (arstN),
        .push     (rasPush),
        .pop      (rasPop),
        .pushAddr (upd.rec.pc + 32'd8),
        .top      (rasTop)
    );

endmodule

// ==== design/returnStack.sv ====
// return address stack, a circular buffer of call return addresses with push and pop
`timescale 1ns/1ns

module returnStack (
    input  logic        clk,
    input  logic        arstN,
    input  logic        push,
    input  logic        pop,
    input  logic [31:0] pushAddr,
    output logic [31:0] top
);
    import bpuConfigPkg::*;

    logic [31:0]        stackMem [rasDepth];
    logic [rasPtrW-1:0] ptr;
    logic [rasPtrW-1:0] ptrNext;

    // pointer wraps on both ends and overflow drops the oldest entry
    always_comb begin
        ptrNext = ptr;
        if (push) begin
            ptrNext = ptr + 1'b1;
        end else if (pop) begin
            ptrNext = ptr - 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ptr <= '0;
        end else begin
            ptr <= ptrNext;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            stackMem[ptrNext] <= pushAddr; // write above the current top
        end
    end

    assign top = stackMem[ptr];

endmodule

// ==== design/bpuUpdateIf.sv ====
// resolution update channel from the execute-stage resolver to the fetch predictor
`timescale 1ns/1ns

interface bpuUpdateIf;
    import bpuTypesPkg::*;

    // no ready, predictor takes every valid record at the next edge
    updateRecT rec;

    modport res (
        output rec
    );

    modport pred (
        input rec
    );

endinterface

// ==== design/bpuConfigPkg.sv ====
// branch predictor sizing of the target buffer and the return stack
package bpuConfigPkg;

    localparam int btbEntries = 64;
    localparam int btbIndexW  = $clog2(btbEntries); // index is pc[7:2]
    localparam int btbTagW    = 32 - btbIndexW - 2; // tag is pc[31:8]

    localparam int rasDepth = 8;
    localparam int rasPtrW  = $clog2(rasDepth);

    // new entries start weakly taken
    localparam logic [1:0] counterInit = 2'd2;

endpackage

// ==== design/bpuTypesPkg.sv ====
// branch types package with the branch codes, the branch kinds and the prediction and resolution records
package bpuTypesPkg;

    // condition code carried with a decoded branch or jump
    typedef enum logic [2:0] {
        BEQ = 3'd0,
        BNE = 3'd1,
        BGE = 3'd2, // rs >= 0
        BGT = 3'd3, // rs > 0
        BLE = 3'd4, // rs <= 0
        BLT = 3'd5, // rs < 0
        J   = 3'd6, // absolute jump, j or jal
        JR  = 3'd7  // register jump, jr or jalr
    } branchCodeT;

    // what the target buffer remembers about a branch
    typedef enum logic [1:0] {
        kindNone = 2'd0,
        kindImme = 2'd1, // direct target, counter decides direction
        kindCall = 2'd2, // pushes the return address
        kindRetn = 2'd3  // target from the return stack
    } branchKindT;

    typedef logic [1:0] counterT; // 2-bit saturating counter

    // decode output describing the instruction in execute
    typedef struct packed {
        logic       isBranch;
        branchCodeT branchCode;
    } branchTypeT;

    // prediction made at fetch, carried down the pipeline
    typedef struct packed {
        logic        valid;
        logic        hit;
        branchKindT  kind;
        logic        isTaken;
        logic [31:0] target;
        counterT     count;
    } predResultT;

    // resolved outcome sent back to the predictor
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        branchKindT  kind;
        logic        isTaken;
        logic [31:0] target;
        counterT     count; // counter value seen at fetch
        logic        hit;   // entry matched at fetch
    } updateRecT;

endpackage
